// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) source/rv_pkg.sv source/rv_fetch.sv source/rv_decode.sv \
		source/rv_regfile.sv source/rv_alu.sv source/rv_lsu.sv source/rv_core.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
+incdir+test
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_core.sv
test/tb_rv_core.sv

// File: source/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  word_t      a,
  input  word_t      b,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  alu_op_t    alu_op,
  input  logic [2:0] funct3,
  output word_t      alu_result,
  output logic       branch_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  // Shift amount from low bits of b
  assign shamt = b[4:0];

  // ------------------------------
  // Arithmetic and logic
  // ------------------------------
  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = a + b;
      ALU_SUB:    alu_result = a - b;
      ALU_SLL:    alu_result = a << shamt;
      ALU_SLT:    alu_result = {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU:   alu_result = {31'd0, a < b};
      ALU_XOR:    alu_result = a ^ b;
      ALU_SRL:    alu_result = a >> shamt;
      ALU_SRA:    alu_result = word_t'($signed(a) >>> shamt);
      ALU_OR:     alu_result = a | b;
      ALU_AND:    alu_result = a & b;
      ALU_PASS_B: alu_result = b;
      default:    alu_result = a + b;
    endcase
  end

  // ------------------------------
  // Branch comparison
  // ------------------------------

  // Always on the register values and independent of operand muxes
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      F3_BEQ:  branch_taken = eq;
      F3_BNE:  branch_taken = !eq;
      F3_BLT:  branch_taken = lt;
      F3_BGE:  branch_taken = !lt;
      F3_BLTU: branch_taken = ltu;
      F3_BGEU: branch_taken = !ltu;
      // 010 and 011 are not branches
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic   clk,
  input  logic   rst_n,
  // Instruction memory answers in the same cycle
  output word_t  imem_raddr,
  input  word_t  imem_rdata,
  // Data memory read
  output logic   dmem_ren,
  output word_t  dmem_raddr,
  input  word_t  dmem_rdata,
  // Data memory write lands at the next edge
  output logic   dmem_we,
  output word_t  dmem_waddr,
  output word_t  dmem_wdata,
  output wstrb_t dmem_wstrb,
  output logic   ebreak,
  output logic   trap
);

  word_t      pc;
  logic       halted;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       alu_a_pc;
  logic       alu_b_imm;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  res_src_t   res_src;
  logic [2:0] funct3;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic       is_ebreak;
  logic       is_illegal;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic       branch_taken;
  word_t      load_data;
  word_t      rd_data;
  logic       active;

  // Not in reset and not halted
  assign active = rst_n && !halted;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) fetch0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .is_branch   (is_branch),
    .branch_taken(branch_taken),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_ebreak   (is_ebreak),
    .is_illegal  (is_illegal),
    .alu_result  (alu_result),
    .imm         (imm),
    .pc          (pc),
    .halted      (halted),
    .ebreak      (ebreak),
    .trap        (trap)
  );

  assign imem_raddr = pc;

  rv_decode decode0 (
    .instr     (imem_rdata),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .alu_a_pc  (alu_a_pc),
    .alu_b_imm (alu_b_imm),
    .reg_write (reg_write),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .res_src   (res_src),
    .funct3    (funct3),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_ebreak (is_ebreak),
    .is_illegal(is_illegal)
  );

  rv_regfile regfile0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .write_en(reg_write && active),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // ------------------------------
  // Operand muxes and execute
  // ------------------------------
  assign alu_a = alu_a_pc ? pc : rs1_data;
  assign alu_b = alu_b_imm ? imm : rs2_data;

  rv_alu alu0 (
    .a           (alu_a),
    .b           (alu_b),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alu_op      (alu_op),
    .funct3      (funct3),
    .alu_result  (alu_result),
    .branch_taken(branch_taken)
  );

  // ------------------------------
  // Data memory
  // ------------------------------
  rv_lsu lsu0 (
    .addr      (alu_result),
    .store_data(rs2_data),
    .load_word (dmem_rdata),
    .funct3    (funct3),
    .wdata     (dmem_wdata),
    .wstrb     (dmem_wstrb),
    .load_data (load_data)
  );

  // Word-aligned addresses with the lane chosen by strobes
  assign dmem_raddr = {alu_result[31:2], 2'b00};
  assign dmem_waddr = {alu_result[31:2], 2'b00};
  assign dmem_ren   = mem_read && active;
  assign dmem_we    = mem_write && active;

  // Write-back source
  always_comb begin
    case (res_src)
      RES_MEM: rd_data = load_data;
      RES_PC4: rd_data = pc + 32'd4;
      default: rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode import rv_pkg::*; (
  input  word_t      instr,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output word_t      imm,
  output alu_op_t    alu_op,
  output logic       alu_a_pc,
  output logic       alu_b_imm,
  output logic       reg_write,
  output logic       mem_read,
  output logic       mem_write,
  output res_src_t   res_src,
  output logic [2:0] funct3,
  output logic       is_branch,
  output logic       is_jal,
  output logic       is_jalr,
  output logic       is_ebreak,
  output logic       is_illegal
);

  logic [6:0] opcode;
  logic       funct7_5;
  alu_op_t    int_op;

  // ------------------------------
  // Field split
  // ------------------------------
  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  // Selects SUB and SRA
  assign funct7_5 = instr[30];

  // Immediate by format
  always_comb begin
    case (opcode)
      OP_STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OP_BRANCH: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OP_LUI, OP_AUIPC: begin
        imm = {instr[31:12], 12'h000};
      end
      OP_JAL: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      // I format for loads, JALR, I-type and the rest
      default: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
    endcase
  end

  // Integer operation from funct3
  always_comb begin
    case (funct3)
      // SUB only exists in R-type
      F3_ADD:  int_op = (opcode == OP_RTYPE && funct7_5) ? ALU_SUB : ALU_ADD;
      F3_SLL:  int_op = ALU_SLL;
      F3_SLT:  int_op = ALU_SLT;
      F3_SLTU: int_op = ALU_SLTU;
      F3_XOR:  int_op = ALU_XOR;
      F3_SR:   int_op = funct7_5 ? ALU_SRA : ALU_SRL;
      F3_OR:   int_op = ALU_OR;
      default: int_op = ALU_AND;
    endcase
  end

  // ------------------------------
  // Control flags
  // ------------------------------
  always_comb begin
    // Default is an add with no write and no memory access
    alu_op     = ALU_ADD;
    alu_a_pc   = 1'b0;
    alu_b_imm  = 1'b0;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    res_src    = RES_ALU;
    is_branch  = 1'b0;
    is_jal     = 1'b0;
    is_jalr    = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      OP_LUI: begin
        alu_op    = ALU_PASS_B;
        alu_b_imm = 1'b1;
        reg_write = 1'b1;
      end
      OP_AUIPC: begin
        alu_a_pc  = 1'b1;
        alu_b_imm = 1'b1;
        reg_write = 1'b1;
      end
      OP_JAL: begin
        // Target pc plus imm is formed in fetch
        reg_write = 1'b1;
        res_src   = RES_PC4;
        is_jal    = 1'b1;
      end
      OP_JALR: begin
        alu_b_imm = 1'b1;
        reg_write = 1'b1;
        res_src   = RES_PC4;
        is_jalr   = 1'b1;
      end
      OP_BRANCH: begin
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        alu_b_imm = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
        res_src   = RES_MEM;
      end
      OP_STORE: begin
        alu_b_imm = 1'b1;
        mem_write = 1'b1;
      end
      OP_ITYPE: begin
        alu_op    = int_op;
        alu_b_imm = 1'b1;
        reg_write = 1'b1;
      end
      OP_RTYPE: begin
        alu_op    = int_op;
        reg_write = 1'b1;
      end
      OP_SYSTEM: begin
        // EBREAK is funct12 = 1, funct3 = 0; ECALL and others retire as no-ops
        is_ebreak = (instr[31:20] == 12'h001) && (funct3 == 3'b000);
      end
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  is_branch,
  input  logic  branch_taken,
  input  logic  is_jal,
  input  logic  is_jalr,
  input  logic  is_ebreak,
  input  logic  is_illegal,
  input  word_t alu_result,
  input  word_t imm,
  output word_t pc,
  output logic  halted,
  output logic  ebreak,
  output logic  trap
);

  word_t pc_next;

  // Either sticky flag stops the core
  assign halted = ebreak || trap;

  // Next PC choice
  always_comb begin
    if (is_jalr) begin
      // JALR target drops bit 0
      pc_next = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && branch_taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else if (!halted) begin
      // Flags are clear here, so plain assignment is sticky
      ebreak <= is_ebreak;
      trap   <= is_illegal;
      // PC stays on the halting instruction
      if (!is_ebreak && !is_illegal) begin
        pc <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  word_t      addr,
  input  word_t      store_data,
  input  word_t      load_word,
  input  logic [2:0] funct3,
  output word_t      wdata,
  output wstrb_t     wstrb,
  output word_t      load_data
);

  word_t shifted;

  // ------------------------------
  // Store lanes
  // ------------------------------
  always_comb begin
    case (funct3[1:0])
      F3_BYTE[1:0]: begin
        // Byte copied to every lane and the strobe picks one
        wdata = {4{store_data[7:0]}};
        wstrb = 4'b0001 << addr[1:0];
      end
      F3_HALF[1:0]: begin
        wdata = {2{store_data[15:0]}};
        wstrb = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = store_data;
        wstrb = 4'b1111;
      end
    endcase
  end

  // ------------------------------
  // Load extraction
  // ------------------------------

  // Addressed lane moved down to bit 0
  assign shifted = load_word >> {addr[1:0], 3'b000};

  always_comb begin
    case (funct3)
      F3_BYTE:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      F3_HALF:   load_data = {{16{shifted[15]}}, shifted[15:0]};
      F3_BYTE_U: load_data = {24'd0, shifted[7:0]};
      F3_HALF_U: load_data = {16'd0, shifted[15:0]};
      default:   load_data = load_word;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ------------------------------
  // Widths that carry a meaning
  // ------------------------------

  // Data and address word
  typedef logic [31:0] word_t;
  // Register index x0..x31
  typedef logic [4:0] reg_addr_t;
  // One bit per byte lane of a word
  typedef logic [3:0] wstrb_t;
  // ALU operation selector
  typedef logic [3:0] alu_op_t;
  // Write-back source selector
  typedef logic [1:0] res_src_t;

  // ALU operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // Operand b straight through for LUI
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // Write-back sources
  localparam res_src_t RES_ALU = 2'd0;
  localparam res_src_t RES_MEM = 2'd1;
  localparam res_src_t RES_PC4 = 2'd2;

  // ------------------------------
  // Major opcodes
  // ------------------------------
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_ITYPE  = 7'b0010011;
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ------------------------------
  // funct3 values
  // ------------------------------

  // Branch kinds
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load and store widths where the U forms zero-extend
  localparam logic [2:0] F3_BYTE   = 3'b000;
  localparam logic [2:0] F3_HALF   = 3'b001;
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_BYTE_U = 3'b100;
  localparam logic [2:0] F3_HALF_U = 3'b101;

  // Integer operations shared by R-type and I-type
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

endpackage

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      write_en,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  // Only x1..x31 have storage
  word_t regs [1:31];

  // Write port
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd != 5'd0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Read ports where x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: test/tb_rv_program.svh
`ifndef TB_RV_PROGRAM_SVH
`define TB_RV_PROGRAM_SVH

// ------------------------------
// Instruction encoders
// ------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Append one instruction at the next word
task automatic emit_instr(input logic [31:0] instr);
  imem[prog_len[6:0]] = instr;
  prog_len++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
  exp_addr.push_back(addr);
  exp_strb.push_back(strb);
  exp_data.push_back(data);
endtask

// R-type on x1/x2 into x3 and stored at 0x200 + off
task automatic alu_store(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                         input logic [31:0] off, input logic [31:0] value);
  emit_instr(enc_r(f7, 5'd2, rs1, f3, 5'd3));
  emit_instr(enc_s(off, 5'd3, 5'd11, 3'b010));
  expect_store(32'h200 + off, 4'hF, value);
endtask

// Load from 0x100 + loff into x5 and stored back at 0x200 + soff
task automatic load_store(input logic [2:0] f3, input logic [31:0] loff,
                          input logic [31:0] soff, input logic [31:0] value);
  emit_instr(enc_i(loff, 5'd10, f3, 5'd5, 7'b0000011));
  emit_instr(enc_s(soff, 5'd5, 5'd11, 3'b010));
  expect_store(32'h200 + soff, 4'hF, value);
endtask

// Taken form skips a bad store and the not-taken form reaches a marker of 5
task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
                           input logic [4:0] n1, input logic [4:0] n2,
                           input logic [31:0] off);
  emit_instr(enc_b(32'd8, t1, t2, f3));
  emit_instr(enc_s(32'h90, 5'd1, 5'd11, 3'b010));
  emit_instr(enc_b(32'd8, n1, n2, f3));
  emit_instr(enc_s(off, 5'd2, 5'd11, 3'b010));
  expect_store(32'h200 + off, 4'hF, 32'h0000_0005);
endtask

// ------------------------------
// Main program ending in EBREAK
// ------------------------------
task automatic load_main_program();
  // x1 = -12, x2 = 5, x11 store base, x10 load base
  emit_instr(enc_i(-32'sd12, 5'd0, 3'b000, 5'd1, 7'b0010011));
  emit_instr(enc_i(32'd5, 5'd0, 3'b000, 5'd2, 7'b0010011));
  emit_instr(enc_i(32'h200, 5'd0, 3'b000, 5'd11, 7'b0010011));
  emit_instr(enc_i(32'h100, 5'd0, 3'b000, 5'd10, 7'b0010011));
  alu_store(7'h00, 3'b000, 5'd1, 32'h00, 32'hFFFF_FFF9);
  alu_store(7'h20, 3'b000, 5'd1, 32'h04, 32'hFFFF_FFEF);
  alu_store(7'h00, 3'b001, 5'd2, 32'h08, 32'h0000_00A0);
  alu_store(7'h00, 3'b101, 5'd1, 32'h0C, 32'h07FF_FFFF);
  alu_store(7'h20, 3'b101, 5'd1, 32'h10, 32'hFFFF_FFFF);
  alu_store(7'h00, 3'b010, 5'd1, 32'h14, 32'h0000_0001);
  alu_store(7'h00, 3'b011, 5'd1, 32'h18, 32'h0000_0000);
  alu_store(7'h00, 3'b100, 5'd1, 32'h1C, 32'hFFFF_FFF1);
  alu_store(7'h00, 3'b110, 5'd1, 32'h20, 32'hFFFF_FFF5);
  alu_store(7'h00, 3'b111, 5'd1, 32'h24, 32'h0000_0004);
  // LUI, then AUIPC at pc 0x68
  emit_instr({20'h12345, 5'd3, 7'b0110111});
  emit_instr(enc_s(32'h28, 5'd3, 5'd11, 3'b010));
  expect_store(32'h228, 4'hF, 32'h1234_5000);
  emit_instr({20'h00001, 5'd3, 7'b0010111});
  emit_instr(enc_s(32'h2C, 5'd3, 5'd11, 3'b010));
  expect_store(32'h22C, 4'hF, 32'h0000_1068);
  // XORI with -1 and SRAI by 2
  emit_instr(enc_i(-32'sd1, 5'd1, 3'b100, 5'd3, 7'b0010011));
  emit_instr(enc_s(32'h30, 5'd3, 5'd11, 3'b010));
  expect_store(32'h230, 4'hF, 32'h0000_000B);
  emit_instr(enc_i(32'h402, 5'd1, 3'b101, 5'd3, 7'b0010011));
  emit_instr(enc_s(32'h34, 5'd3, 5'd11, 3'b010));
  expect_store(32'h234, 4'hF, 32'hFFFF_FFFD);
  // x4 = 0xAABBCCDD for the lane tests
  emit_instr({20'hAABBD, 5'd4, 7'b0110111});
  emit_instr(enc_i(-32'sd803, 5'd4, 3'b000, 5'd4, 7'b0010011));
  for (int i = 0; i < 4; i++) begin
    emit_instr(enc_s(32'h40 + i, 5'd4, 5'd11, 3'b000));
    expect_store(32'h240, 4'b0001 << i, 32'hDDDD_DDDD);
  end
  emit_instr(enc_s(32'h44, 5'd4, 5'd11, 3'b001));
  expect_store(32'h244, 4'b0011, 32'hCCDD_CCDD);
  emit_instr(enc_s(32'h46, 5'd4, 5'd11, 3'b001));
  expect_store(32'h244, 4'b1100, 32'hCCDD_CCDD);
  // Loads of the preloaded word 0x8765F0A1
  load_store(3'b000, 32'd0, 32'h50, 32'hFFFF_FFA1);
  load_store(3'b100, 32'd0, 32'h54, 32'h0000_00A1);
  load_store(3'b000, 32'd1, 32'h58, 32'hFFFF_FFF0);
  load_store(3'b001, 32'd2, 32'h5C, 32'hFFFF_8765);
  load_store(3'b101, 32'd2, 32'h60, 32'h0000_8765);
  load_store(3'b010, 32'd0, 32'h64, 32'h8765_F0A1);
  // x1 is -12 and x2 is 5
  branch_pair(3'b000, 5'd2, 5'd2, 5'd1, 5'd2, 32'h70);
  branch_pair(3'b001, 5'd1, 5'd2, 5'd2, 5'd2, 32'h74);
  branch_pair(3'b100, 5'd1, 5'd2, 5'd2, 5'd1, 32'h78);
  branch_pair(3'b101, 5'd2, 5'd1, 5'd1, 5'd2, 32'h7C);
  branch_pair(3'b110, 5'd2, 5'd1, 5'd1, 5'd2, 32'h80);
  branch_pair(3'b111, 5'd1, 5'd2, 5'd2, 5'd1, 32'h84);
  // JAL at 0x130 links 0x134
  emit_instr(enc_j(32'd8, 5'd7));
  emit_instr(enc_s(32'h90, 5'd1, 5'd11, 3'b010));
  emit_instr(enc_s(32'h88, 5'd7, 5'd11, 3'b010));
  expect_store(32'h288, 4'hF, 32'h0000_0134);
  // AUIPC at 0x13C, JALR to 0x13C + 13 with bit 0 dropped
  emit_instr({20'h00000, 5'd8, 7'b0010111});
  emit_instr(enc_i(32'd13, 5'd8, 3'b000, 5'd9, 7'b1100111));
  emit_instr(enc_s(32'h90, 5'd1, 5'd11, 3'b010));
  emit_instr(enc_s(32'h8C, 5'd9, 5'd11, 3'b010));
  expect_store(32'h28C, 4'hF, 32'h0000_0144);
  halt_addr = prog_len * 4;
  emit_instr(32'h0010_0073);
endtask

// ------------------------------
// Trap program
// ------------------------------
task automatic load_trap_program();
  emit_instr(enc_i(32'h55, 5'd0, 3'b000, 5'd1, 7'b0010011));
  emit_instr(enc_s(32'h300, 5'd1, 5'd0, 3'b010));
  expect_store(32'h300, 4'hF, 32'h0000_0055);
  halt_addr = prog_len * 4;
  // Opcode 0x7F is not RV32I
  emit_instr(32'hFFFF_FFFF);
  emit_instr(enc_s(32'h304, 5'd1, 5'd0, 3'b010));
  emit_instr(32'h0010_0073);
endtask

`endif

// File: test/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        ebreak;
  logic        trap;

  // Memory models and expected store records
  logic [31:0] imem [0:127];
  logic [31:0] dmem [0:255];
  logic [31:0] exp_addr [$];
  logic [3:0]  exp_strb [$];
  logic [31:0] exp_data [$];
  int          prog_len;
  int          halt_addr;

  `include "tb_rv_program.svh"

  rv_core #(
    .RESET_PC(32'h0000_0000)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Zero-latency memories
  assign imem_rdata = imem[imem_raddr[8:2]];
  // Data reads return zero unless the core enables them
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : 32'h0;

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_wstrb[i]) begin
          dmem[dmem_waddr[9:2]][i*8 +: 8] <= dmem_wdata[i*8 +: 8];
        end
      end
    end
  end

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // ------------------------------
  // Store monitor
  // ------------------------------
  always @(posedge clk) begin
    if (dmem_we) begin
      assert (exp_addr.size() != 0)
        else fail($sformatf("Unexpected store to %h", dmem_waddr));
      if (exp_addr.size() != 0) begin
        assert (dmem_waddr == exp_addr[0])
          else fail($sformatf("MISMATCH dmem_waddr: expected %h got %h",
                              exp_addr[0], dmem_waddr));
        assert (dmem_wstrb == exp_strb[0])
          else fail($sformatf("MISMATCH dmem_wstrb: expected %h got %h",
                              exp_strb[0], dmem_wstrb));
        assert (dmem_wdata == exp_data[0])
          else fail($sformatf("MISMATCH dmem_wdata: expected %h got %h",
                              exp_data[0], dmem_wdata));
        void'(exp_addr.pop_front());
        void'(exp_strb.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  // Refill both memories and hold reset while the program loads
  task automatic start_reset();
    prog_len = 0;
    for (int i = 0; i < 128; i++) begin
      // Opcode 0 is illegal so a stray fetch traps
      imem[i] = {i[24:0], 7'b000_0000};
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'hA5A5_0000 | i;
    end
    dmem[64] = 32'h8765_F0A1;
    @(negedge clk);
    rst_n = 1'b0;
  endtask

  // Release reset, wait for a halt, then watch the core stay halted
  task automatic run_and_hold(input logic want_ebreak);
    int cycles;
    int limit;
    limit = prog_len + 20;
    cycles = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    while (!(ebreak || trap)) begin
      @(posedge clk);
      cycles++;
      assert (cycles <= limit)
        else fail("Timeout: core never halted");
    end
    for (int i = 0; i < 6; i++) begin
      assert (ebreak == want_ebreak)
        else fail($sformatf("MISMATCH ebreak: expected %h got %h", want_ebreak, ebreak));
      assert (trap == !want_ebreak)
        else fail($sformatf("MISMATCH trap: expected %h got %h", !want_ebreak, trap));
      assert (imem_raddr == halt_addr)
        else fail($sformatf("MISMATCH imem_raddr: expected %h got %h",
                            halt_addr, imem_raddr));
      @(posedge clk);
    end
    assert (exp_addr.size() == 0)
      else fail($sformatf("Core halted with %0d expected stores missing", exp_addr.size()));
  endtask

  initial begin
    rst_n = 1'b0;
    start_reset();
    load_main_program();
    run_and_hold(1'b1);
    start_reset();
    load_trap_program();
    run_and_hold(1'b0);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
